//--- common/cb_macros.svh
`ifndef CB_MACROS_SVH
`define CB_MACROS_SVH

// Global widths of the covariance-bank read path.

// Lanes per bank row. The A, B, M and TB vectors share this width.
`define CB_LANES  4

// Width of one covariance word.
`define CB_WORD_W 16

// Row address width, giving 64 rows in the bank.
`define CB_ADDR_W 6

// Width of the step index within one read burst.
`define CB_SEQ_W  10

`endif

//--- common/cb_data_pkg.sv
`include "cb_macros.svh"

// Data types that travel through the covariance-bank read path.
package cb_data_pkg;

  // ==========================================================================
  // Scalar types
  // ==========================================================================

  // One signed covariance word.
  typedef logic signed [`CB_WORD_W-1:0] cb_word_t;

  // Row address into the bank.
  typedef logic [`CB_ADDR_W-1:0] cb_addr_t;

  // Step index within a burst.
  typedef logic [`CB_SEQ_W-1:0] cb_seq_t;

  // ==========================================================================
  // Row types
  // ==========================================================================

  // One bank row. Lane 0 sits in the low word.
  // Every consumer output vector has this same shape.
  typedef cb_word_t [`CB_LANES-1:0] cb_row_t;

  // Depth of the bank, one entry per row address.
  localparam int CB_ROWS = 1 << `CB_ADDR_W;

endpackage

//--- common/cb_ctrl_pkg.sv
`include "cb_macros.svh"

// Control types for the covariance-bank read path.
package cb_ctrl_pkg;

  import cb_data_pkg::*;

  // ==========================================================================
  // Encodings
  // ==========================================================================

  // Consumer that receives the mapped row.
  typedef enum logic [1:0] {
    DEST_TB = 2'd0,
    DEST_A  = 2'd1,
    DEST_B  = 2'd2,
    DEST_M  = 2'd3
  } cb_dest_e;

  // Lane direction applied by the mapper.
  typedef enum logic [1:0] {
    DIR_IDLE = 2'd0,
    DIR_POS  = 2'd1,
    DIR_NEG  = 2'd2,
    DIR_NEW  = 2'd3
  } cb_dir_e;

  // Read controller states.
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,
    ST_DRAIN = 2'd2
  } cb_fsm_e;

  // ==========================================================================
  // Structs
  // ==========================================================================

  // Read command. The len field holds the number of rows minus one.
  typedef struct packed {
    cb_dest_e dest;
    cb_dir_e  dir;
    logic     l_k_0;
    cb_addr_t base;
    cb_seq_t  len;
  } cb_cmd_t;

  // Per-step select that travels alongside the row read from the bank.
  typedef struct packed {
    cb_dest_e dest;
    cb_dir_e  dir;
    logic     l_k_0;
    cb_seq_t  seq;
  } cb_sel_t;

endpackage

//--- rtl/cb_bank_mem.sv
`timescale 1ns/100ps

// Four-lane covariance bank. One row is written or read per cycle on
// each port, and the read port has one cycle of latency.
module cb_bank_mem
  import cb_data_pkg::*;
(
  input  logic     clk,

  // Write port.
  input  logic     i_wr_en,
  input  cb_addr_t i_wr_addr,
  input  cb_row_t  i_wr_data,

  // Registered read port.
  input  logic     i_rd_en,
  input  cb_addr_t i_rd_addr,
  output cb_row_t  o_rd_data
);

  // ==========================================================================
  // Storage
  // ==========================================================================

  cb_row_t mem [CB_ROWS];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // ==========================================================================
  // Read port
  // ==========================================================================

  // The array is sampled before the write of the same edge lands, so a
  // read that collides with a write returns the old row.
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

//--- rtl/seq_step_counter.sv
`timescale 1ns/100ps

// Step counter for one read burst. A clear loads the burst length and
// restarts the count at zero, and each advance moves one step on.
module seq_step_counter
  import cb_data_pkg::*;
(
  input  logic    clk,
  input  logic    sys_rst,
  input  logic    i_clear,
  input  logic    i_advance,
  input  cb_seq_t i_len,
  output cb_seq_t o_seq,
  output logic    o_last
);

  cb_seq_t count_q;
  cb_seq_t len_q;
  // Set by the first clear after reset.
  logic    armed_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      count_q <= '0;
      len_q   <= '0;
      armed_q <= 1'b0;
    end else if (i_clear) begin
      count_q <= '0;
      len_q   <= i_len;
      armed_q <= 1'b1;
    end else if (i_advance && armed_q && !o_last) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign o_seq  = count_q;
  assign o_last = (count_q == len_q);

  // The controller must open every burst with a clear before it steps.
  a_clear_before_advance: assert property (
    @(posedge clk) disable iff (sys_rst) i_advance |-> armed_q
  );

endmodule

//--- rtl/cb_read_fsm.sv
`timescale 1ns/100ps

// Read controller. It accepts one command at a time, walks the rows of
// the burst and hands the mapper a select aligned with each returned row.
module cb_read_fsm
  import cb_data_pkg::*;
  import cb_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,

  // Command side.
  input  logic     i_start,
  input  cb_cmd_t  i_cmd,

  // Step counter.
  input  cb_seq_t  i_seq,
  input  logic     i_last,
  output logic     o_clear,
  output logic     o_advance,

  // Bank read port.
  output logic     o_rd_en,
  output cb_addr_t o_rd_addr,

  // Select towards the mapper.
  output cb_sel_t  o_sel,
  output logic     o_sel_valid,
  output logic     o_busy
);

  // ==========================================================================
  // State
  // ==========================================================================

  cb_fsm_e state_q;
  cb_fsm_e state_d;
  cb_cmd_t cmd_q;
  // High in the second drain cycle.
  logic    drain_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (i_start) state_d = ST_READ;
      ST_READ:  if (i_last)  state_d = ST_DRAIN;
      ST_DRAIN: if (drain_q) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state_q <= ST_IDLE;
      drain_q <= 1'b0;
    end else begin
      state_q <= state_d;
      drain_q <= (state_q == ST_DRAIN) && !drain_q;
    end
  end

  // The command is held for the whole burst.
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && i_start) begin
      cmd_q <= i_cmd;
    end
  end

  // ==========================================================================
  // Read issue
  // ==========================================================================

  assign o_clear   = (state_q == ST_IDLE) && i_start;
  assign o_rd_en   = (state_q == ST_READ);
  assign o_advance = o_rd_en && !i_last;
  assign o_rd_addr = cmd_q.base + cb_addr_t'(i_seq);
  assign o_busy    = (state_q != ST_IDLE);

  // The bank answers one cycle after the address, so the select is
  // delayed by one register to meet its row at the mapper.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_sel_valid <= 1'b0;
    end else begin
      o_sel_valid <= o_rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (o_rd_en) begin
      o_sel.dest  <= cmd_q.dest;
      o_sel.dir   <= cmd_q.dir;
      o_sel.l_k_0 <= cmd_q.l_k_0;
      o_sel.seq   <= i_seq;
    end
  end

  // Without an accepted start the controller stays idle and issues no read.
  a_no_read_in_idle: assert property (
    @(posedge clk) disable iff (sys_rst) (state_q == ST_IDLE) && !i_start |=> !o_rd_en
  );

endmodule

//--- cb_map/cb_douta_map.sv
`timescale 1ns/100ps

`include "cb_macros.svh"

// Output mapper. Each valid step steers the bank row to one consumer
// and rearranges its lanes by the requested direction. All four output
// vectors are registered and read zero when their consumer is not chosen.
module cb_douta_map
  import cb_data_pkg::*;
  import cb_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    sys_rst,
  input  cb_sel_t i_sel,
  input  logic    i_sel_valid,
  input  cb_row_t i_row,
  output cb_row_t o_tb_row,
  output cb_row_t o_a_row,
  output cb_row_t o_b_row,
  output cb_row_t o_m_row,
  output logic    o_out_valid
);

  // ==========================================================================
  // Lane mapping for the systolic array operands
  // ==========================================================================

  // A, B and M share one mapping. For a new landmark the low landmark
  // bit picks the lower or the upper lane pair.
  function automatic cb_row_t operand_map(cb_dir_e dir, logic l_k_0, cb_row_t row);
    cb_row_t res;
    res = '0;
    case (dir)
      DIR_POS: begin
        res = row;
      end
      DIR_NEG: begin
        for (int i = 0; i < `CB_LANES; i++) begin
          res[i] = row[`CB_LANES-1-i];
        end
      end
      DIR_NEW: begin
        res[0] = l_k_0 ? row[0] : row[2];
        res[1] = l_k_0 ? row[1] : row[3];
      end
      default: begin
        res = '0;
      end
    endcase
    return res;
  endfunction

  // ==========================================================================
  // Lane mapping for the temporary buffer
  // ==========================================================================

  // Only the new-landmark sequence writes the buffer. The selected pair
  // slides across the buffer lanes over steps 0 to 4.
  function automatic cb_row_t tb_map(cb_dir_e dir, logic l_k_0, cb_seq_t seq,
                                     cb_row_t row);
    cb_row_t  res;
    cb_word_t first;
    cb_word_t second;
    res    = '0;
    first  = l_k_0 ? row[1] : row[3];
    second = l_k_0 ? row[0] : row[2];
    if (dir == DIR_NEW) begin
      case (seq)
        0: begin
          res[3] = first;
        end
        1: begin
          res[0] = second;
        end
        2: begin
          res[0] = first;
          res[1] = second;
        end
        3: begin
          res[1] = first;
          res[2] = second;
        end
        4: begin
          res[2] = first;
          res[3] = second;
        end
        default: begin
          res = '0;
        end
      endcase
    end
    return res;
  endfunction

  // ==========================================================================
  // Output registers
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_tb_row    <= '0;
      o_a_row     <= '0;
      o_b_row     <= '0;
      o_m_row     <= '0;
      o_out_valid <= 1'b0;
    end else begin
      o_tb_row <= (i_sel_valid && (i_sel.dest == DEST_TB)) ?
                  tb_map(i_sel.dir, i_sel.l_k_0, i_sel.seq, i_row) : '0;
      o_a_row  <= (i_sel_valid && (i_sel.dest == DEST_A)) ?
                  operand_map(i_sel.dir, i_sel.l_k_0, i_row) : '0;
      o_b_row  <= (i_sel_valid && (i_sel.dest == DEST_B)) ?
                  operand_map(i_sel.dir, i_sel.l_k_0, i_row) : '0;
      o_m_row  <= (i_sel_valid && (i_sel.dest == DEST_M)) ?
                  operand_map(i_sel.dir, i_sel.l_k_0, i_row) : '0;
      o_out_valid <= i_sel_valid;
    end
  end

  // The new-landmark mapping names lanes 0 to 3 directly.
  a_four_lanes: assert property (@(posedge clk) (`CB_LANES == 4));

  // A cycle without a step leaves every consumer with a zero row.
  a_zero_when_idle: assert property (
    @(posedge clk) disable iff (sys_rst)
    !i_sel_valid |=> (o_tb_row == '0) && (o_a_row == '0) &&
                     (o_b_row == '0) && (o_m_row == '0) && !o_out_valid
  );

endmodule

//--- rtl/cb_read_top.sv
`timescale 1ns/100ps

// Covariance-bank read path. Commands enter here, rows leave mapped for
// the temporary buffer and the three operand ports of the array.
module cb_read_top
  import cb_data_pkg::*;
  import cb_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,

  // Bank fill.
  input  logic     i_wr_en,
  input  cb_addr_t i_wr_addr,
  input  cb_row_t  i_wr_data,

  // Command and status.
  input  logic     i_start,
  input  cb_cmd_t  i_cmd,
  output logic     o_busy,

  // Mapped rows, valid on the strobe only.
  output logic     o_out_valid,
  output cb_row_t  o_tb_row,
  output cb_row_t  o_a_row,
  output cb_row_t  o_b_row,
  output cb_row_t  o_m_row
);

  logic     clear;
  logic     advance;
  cb_seq_t  seq;
  logic     last;
  logic     rd_en;
  cb_addr_t rd_addr;
  cb_row_t  rd_data;
  cb_sel_t  sel;
  logic     sel_valid;

  cb_bank_mem u_bank_mem (
    .clk       (clk),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  // The counter takes the length straight from the command, since it
  // loads it in the same cycle the start is accepted.
  seq_step_counter u_step_counter (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_clear   (clear),
    .i_advance (advance),
    .i_len     (i_cmd.len),
    .o_seq     (seq),
    .o_last    (last)
  );

  cb_read_fsm u_read_fsm (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_start     (i_start),
    .i_cmd       (i_cmd),
    .i_seq       (seq),
    .i_last      (last),
    .o_clear     (clear),
    .o_advance   (advance),
    .o_rd_en     (rd_en),
    .o_rd_addr   (rd_addr),
    .o_sel       (sel),
    .o_sel_valid (sel_valid),
    .o_busy      (o_busy)
  );

  cb_douta_map u_douta_map (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_sel       (sel),
    .i_sel_valid (sel_valid),
    .i_row       (rd_data),
    .o_tb_row    (o_tb_row),
    .o_a_row     (o_a_row),
    .o_b_row     (o_b_row),
    .o_m_row     (o_m_row),
    .o_out_valid (o_out_valid)
  );

endmodule

//--- dv/cb_read_tb.sv
`timescale 1ns/100ps

`include "cb_macros.svh"

// Testbench for the covariance-bank read path. The bank is filled with
// LFSR data and a table of read commands is replayed against a shadow copy.
module cb_read_tb
  import cb_data_pkg::*;
  import cb_ctrl_pkg::*;
;

  localparam int RST_CYCLES   = 10;
  localparam int NUM_TESTS    = 18;
  localparam int SETUP_CYCLES = RST_CYCLES + CB_ROWS + 4;

  logic     clk;
  logic     sys_rst;
  logic     i_wr_en;
  cb_addr_t i_wr_addr;
  cb_row_t  i_wr_data;
  logic     i_start;
  cb_cmd_t  i_cmd;
  logic     o_busy;
  logic     o_out_valid;
  cb_row_t  o_tb_row;
  cb_row_t  o_a_row;
  cb_row_t  o_b_row;
  cb_row_t  o_m_row;

  cb_row_t     shadow [CB_ROWS];
  string       test_name [NUM_TESTS];
  cb_cmd_t     test_cmd [NUM_TESTS];
  logic        test_poke [NUM_TESTS];
  int          test_count  = 0;
  logic        table_ready = 1'b0;
  logic [15:0] lfsr_state  = 16'd82;
  int          row_errors  = 0;
  int          flag_errors = 0;
  int          step_errors = 0;

  cb_read_top DUT (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_wr_en     (i_wr_en),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_start     (i_start),
    .i_cmd       (i_cmd),
    .o_busy      (o_busy),
    .o_out_valid (o_out_valid),
    .o_tb_row    (o_tb_row),
    .o_a_row     (o_a_row),
    .o_b_row     (o_b_row),
    .o_m_row     (o_m_row)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================================
  // Compare tasks
  // ==========================================================================

  task automatic check_row(input string name, input string what, input cb_row_t exp,
                           input cb_row_t act);
    if (exp !== act) begin
      row_errors++;
      $display("ERROR %s %s: expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (exp !== act) begin
      flag_errors++;
      $display("ERROR %s %s: expected %b actual %b", name, what, exp, act);
    end
  endtask

  task automatic compare_step(input string name, input string what, input cb_seq_t exp,
                              input cb_seq_t act);
    if (exp !== act) begin
      step_errors++;
      $display("ERROR %s %s: expected %0d actual %0d", name, what, exp, act);
    end
  endtask

  // ==========================================================================
  // Reference mapping
  // ==========================================================================

  // Operand ports. Reversal flips the 2-bit lane index, and a new landmark
  // takes the pair whose upper index bit is the inverse of l_k_0.
  function automatic cb_row_t expect_operand(cb_dir_e dir, logic l_k_0, cb_row_t row);
    cb_row_t    res;
    logic [1:0] lane;
    res = '0;
    for (int p = 0; p < `CB_LANES; p++) begin
      lane = 2'(p);
      if (dir == DIR_POS) begin
        res[lane] = row[lane];
      end else if (dir == DIR_NEG) begin
        res[lane] = row[~lane];
      end else if ((dir == DIR_NEW) && (p < 2)) begin
        res[lane] = row[{~l_k_0, lane[0]}];
      end
    end
    return res;
  endfunction

  // Temporary buffer. The first word lands at place 3 on step 0, then the
  // pair moves one place up per step from step 2 on.
  function automatic cb_row_t expect_tb(cb_dir_e dir, logic l_k_0, cb_seq_t step,
                                        cb_row_t row);
    cb_row_t    res;
    logic [1:0] first_place;
    logic [1:0] second_place;
    logic       first_on;
    logic       second_on;
    res          = '0;
    first_on     = (dir == DIR_NEW) && (step <= 4) && (step != 1);
    second_on    = (dir == DIR_NEW) && (step <= 4) && (step != 0);
    first_place  = (step == 0) ? 2'd3 : 2'(int'(step) - 2);
    second_place = 2'(int'(step) - 1);
    if (first_on) begin
      res[first_place] = row[{~l_k_0, 1'b1}];
    end
    if (second_on) begin
      res[second_place] = row[{~l_k_0, 1'b0}];
    end
    return res;
  endfunction

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_row(output cb_row_t row);
    logic [63:0] bits;
    for (int b = 0; b < 64; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[b]    = lfsr_state[0];
    end
    row = bits;
  endtask

  task automatic fill_bank();
    cb_row_t row;
    for (int a = 0; a < CB_ROWS; a++) begin
      random_row(row);
      shadow[a] = row;
      @(posedge clk);
      i_wr_en   <= 1'b1;
      i_wr_addr <= cb_addr_t'(a);
      i_wr_data <= row;
    end
    @(posedge clk);
    i_wr_en <= 1'b0;
  endtask

  task automatic add_test(input string name, input cb_dest_e dest, input cb_dir_e dir,
                          input logic l_k_0, input cb_addr_t base, input cb_seq_t len,
                          input logic poke);
    test_name[test_count]      = name;
    test_cmd[test_count].dest  = dest;
    test_cmd[test_count].dir   = dir;
    test_cmd[test_count].l_k_0 = l_k_0;
    test_cmd[test_count].base  = base;
    test_cmd[test_count].len   = len;
    test_poke[test_count]      = poke;
    test_count++;
  endtask

  task automatic load_table();
    add_test("a_pos", DEST_A, DIR_POS, 1'b0, 6'd3, 10'd3, 1'b0);
    add_test("a_neg", DEST_A, DIR_NEG, 1'b0, 6'd8, 10'd2, 1'b0);
    add_test("b_pos", DEST_B, DIR_POS, 1'b1, 6'd12, 10'd1, 1'b0);
    add_test("b_neg", DEST_B, DIR_NEG, 1'b0, 6'd16, 10'd3, 1'b0);
    add_test("m_pos_single", DEST_M, DIR_POS, 1'b0, 6'd22, 10'd0, 1'b0);
    add_test("m_neg_wrap", DEST_M, DIR_NEG, 1'b1, 6'd62, 10'd3, 1'b0);
    add_test("a_new_l1", DEST_A, DIR_NEW, 1'b1, 6'd5, 10'd2, 1'b0);
    add_test("a_new_l0", DEST_A, DIR_NEW, 1'b0, 6'd9, 10'd2, 1'b0);
    add_test("b_new_l1", DEST_B, DIR_NEW, 1'b1, 6'd14, 10'd1, 1'b0);
    add_test("b_new_l0", DEST_B, DIR_NEW, 1'b0, 6'd18, 10'd1, 1'b0);
    add_test("m_new_l1", DEST_M, DIR_NEW, 1'b1, 6'd25, 10'd2, 1'b0);
    add_test("m_new_l0", DEST_M, DIR_NEW, 1'b0, 6'd27, 10'd2, 1'b0);
    add_test("tb_new_l1", DEST_TB, DIR_NEW, 1'b1, 6'd20, 10'd4, 1'b0);
    add_test("tb_new_l0", DEST_TB, DIR_NEW, 1'b0, 6'd30, 10'd4, 1'b0);
    add_test("tb_new_long", DEST_TB, DIR_NEW, 1'b1, 6'd40, 10'd8, 1'b0);
    add_test("a_idle", DEST_A, DIR_IDLE, 1'b0, 6'd50, 10'd2, 1'b0);
    add_test("tb_pos", DEST_TB, DIR_POS, 1'b0, 6'd44, 10'd2, 1'b0);
    add_test("m_pos_busy_start", DEST_M, DIR_POS, 1'b0, 6'd54, 10'd5, 1'b1);
  endtask

  // One burst. Busy and the strobe are checked in every cycle against the
  // fixed pipeline timing, and every strobe is checked against the shadow.
  task automatic run_test(input int t);
    cb_cmd_t  cmd;
    cb_addr_t addr;
    cb_row_t  row;
    int       offset;
    int       strobes;
    cmd     = test_cmd[t];
    offset  = 0;
    strobes = 0;
    @(posedge clk);
    i_start <= 1'b1;
    i_cmd   <= cmd;
    do begin
      @(posedge clk);
      offset++;
      i_start <= test_poke[t] && (offset == 2);
      @(negedge clk);
      check_flag(test_name[t], "busy", offset <= int'(cmd.len) + 3, o_busy);
      check_flag(test_name[t], "out_valid",
                 (offset >= 3) && (offset <= int'(cmd.len) + 3), o_out_valid);
      if (o_out_valid) begin
        addr = cmd.base + cb_addr_t'(strobes);
        row  = shadow[addr];
        compare_step(test_name[t], "strobe step", cb_seq_t'(strobes),
                     cb_seq_t'(offset - 3));
        check_row(test_name[t], "tb_row", (cmd.dest == DEST_TB) ?
                  expect_tb(cmd.dir, cmd.l_k_0, cb_seq_t'(strobes), row) : '0, o_tb_row);
        check_row(test_name[t], "a_row", (cmd.dest == DEST_A) ?
                  expect_operand(cmd.dir, cmd.l_k_0, row) : '0, o_a_row);
        check_row(test_name[t], "b_row", (cmd.dest == DEST_B) ?
                  expect_operand(cmd.dir, cmd.l_k_0, row) : '0, o_b_row);
        check_row(test_name[t], "m_row", (cmd.dest == DEST_M) ?
                  expect_operand(cmd.dir, cmd.l_k_0, row) : '0, o_m_row);
        strobes++;
      end
    end while (o_busy);
    compare_step(test_name[t], "strobe count", cmd.len + 1'b1, cb_seq_t'(strobes));
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    sys_rst   = 1'b1;
    i_wr_en   = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    i_start   = 1'b0;
    i_cmd     = '0;
    load_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    sys_rst <= 1'b0;
    @(negedge clk);
    check_flag("reset", "busy", 1'b0, o_busy);
    check_flag("reset", "out_valid", 1'b0, o_out_valid);
    check_row("reset", "tb_row", '0, o_tb_row);
    check_row("reset", "a_row", '0, o_a_row);
    check_row("reset", "b_row", '0, o_b_row);
    check_row("reset", "m_row", '0, o_m_row);
    fill_bank();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Error counts: rows %0d, flags %0d, steps %0d",
             row_errors, flag_errors, step_errors);
    if ((row_errors + flag_errors + step_errors) == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // The limit allows each burst its length plus five cycles, on top of
  // reset, the bank fill and a fixed margin.
  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = SETUP_CYCLES + 100;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += int'(test_cmd[t].len) + 5;
    end
    repeat (limit) @(posedge clk);
    $display("The run timed out after %0d cycles before all tests completed", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- files.f
+incdir+common
common/cb_data_pkg.sv
common/cb_ctrl_pkg.sv
rtl/cb_bank_mem.sv
rtl/seq_step_counter.sv
rtl/cb_read_fsm.sv
cb_map/cb_douta_map.sv
rtl/cb_read_top.sv
dv/cb_read_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cb_read_tb -f files.f -o cb_read_sim > build.log 2>&1 \
  && ./obj_dir/cb_read_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -qx "Finished with no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
